// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_vp_glue
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
common/vp_glue_pkg.sv
verilog/vp_clock_reset.sv
cart/vp_cart_rom.sv
input/vp_input_front.sv
verilog/vp_video_encoder.sv
verilog/vp_glue_top.sv
testbench/tb_vp_glue.sv

// ==== cart/vp_cart_rom.sv ====
/*
 * Videopac cartridge ROM
 * Wishbone classic download slave filling an on-chip ROM, image size
 * counter and size dependent bank mapping of the console cart bus.
 */
`timescale 1ns/1ps
`default_nettype none

module vp_cart_rom
	import vp_glue_pkg::*;
#(
	parameter int ROM_AW = 13
) (
	input  wire        clk_sys,
	input  wire        reset,
	input  wb_req_t    wb_i,
	output logic       wb_ack_o,
	output logic       dl_active_o,
	input  cart_addr_t cart_addr_i,
	input  logic       bs0_i,
	input  logic       bs1_i,
	input  logic       psen_n_i,
	output byte_t      cart_data_o
);

	wb_state_e state;
	logic      cyc_q;
	size_t     size_q;
	rom_addr_t rom_addr;
	byte_t     rd_q;
	logic      psen_n_q;
	byte_t     mem [2**ROM_AW];

	////////////////////////////////////////
	// Download slave
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= WB_IDLE;
		end else begin
			case (state)
				WB_IDLE: begin
					if (wb_i.cyc && wb_i.stb)
						state <= WB_ACK;
				end
				// Single ack cycle, then back to idle
				default: state <= WB_IDLE;
			endcase
		end
	end

	assign wb_ack_o    = state == WB_ACK;
	assign dl_active_o = wb_i.cyc;

	// Image size, restarted on each new cycle
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cyc_q  <= 1'b0;
			size_q <= '0;
		end else begin
			cyc_q <= wb_i.cyc;
			if (wb_i.cyc && !cyc_q)
				size_q <= '0;
			else if (wb_ack_o && wb_i.we)
				size_q <= size_q + 1'b1;
		end
	end

	////////////////////////////////////////
	// Bank mapping and ROM array
	////////////////////////////////////////

	// Bank bits only count once the image is big enough
	// Cart address bit 10 selects nothing here
	assign rom_addr = {
		(size_q >= size_t'(BANK1_SIZE)) ? bs1_i : 1'b0,
		(size_q >= size_t'(BANK0_SIZE)) ? bs0_i : 1'b0,
		cart_addr_i[11],
		cart_addr_i[9:0]
	};

	// Write lands on the ack cycle
	always_ff @(posedge clk_sys) begin
		if (wb_ack_o && wb_i.we)
			mem[wb_i.adr[ROM_AW-1:0]] <= wb_i.dat;
		rd_q <= mem[rom_addr[ROM_AW-1:0]];
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			psen_n_q <= 1'b1;
		else
			psen_n_q <= psen_n_i;
	end

	// Bus floats high when not strobed
	assign cart_data_o = psen_n_q ? 8'hFF : rd_q;

endmodule

`default_nettype wire

// ==== common/vp_glue_pkg.sv ====
/*
 * Videopac board glue shared definitions
 * Widths, bus structs, download FSM states and default constants
 * used by the clock, cartridge, input and video blocks.
 */
`default_nettype none

package vp_glue_pkg;

	////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////
	typedef logic [7:0]  byte_t;
	typedef logic [11:0] cart_addr_t;
	typedef logic [12:0] rom_addr_t;
	typedef logic [15:0] size_t;
	// Red, green, blue, luma from MSB down
	typedef logic [3:0]  color_idx_t;
	typedef logic [23:0] rgb_t;
	typedef logic [3:0]  snd_t;
	typedef logic [15:0] audio_t;
	// Bit 0 is "1" ... bit 8 is "9", bit 9 is "0"
	typedef logic [9:0]  numpad_t;

	////////////////////////////////////////
	// Structs
	////////////////////////////////////////

	// Key report from the PS/2 host, toggle flips per new key
	typedef struct packed {
		logic  toggle;
		logic  pressed;
		logic  extended;
		byte_t code;
	} ps2_key_t;

	// Event towards the console keyboard mapper
	typedef struct packed {
		logic  ready;
		logic  released;
		byte_t ascii;
	} key_event_t;

	// One gamepad, all buttons active high
	typedef struct packed {
		numpad_t numpad;
		logic    reset;
		logic    action;
		logic    up;
		logic    down;
		logic    left;
		logic    right;
	} joy_t;

	// Console joystick lines, active low
	// Bit 1 player A, bit 0 player B
	typedef struct packed {
		logic [1:0] up;
		logic [1:0] down;
		logic [1:0] left;
		logic [1:0] right;
		logic [1:0] action;
	} joy_pair_t;

	// Wishbone classic request from the download master
	typedef struct packed {
		logic      cyc;
		logic      stb;
		logic      we;
		rom_addr_t adr;
		byte_t     dat;
	} wb_req_t;

	typedef enum logic {
		WB_IDLE,
		WB_ACK
	} wb_state_e;

	////////////////////////////////////////
	// Default constants
	////////////////////////////////////////
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;

	// Visible window in VDC clocks from hsync
	localparam int TRIM_LEFT  = 46;
	localparam int TRIM_RIGHT = 367;

	// Image size thresholds enabling bank bits
	localparam int BANK0_SIZE = 4096;
	localparam int BANK1_SIZE = 8192;

endpackage

`default_nettype wire

// ==== input/vp_input_front.sv ====
/*
 * Videopac input front end
 * Turns PS/2 scancodes and gamepad number buttons into key events
 * for the console keyboard mapper; routes both joysticks active low.
 */
`timescale 1ns/1ps
`default_nettype none

module vp_input_front
	import vp_glue_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  ps2_key_t   ps2_key_i,
	input  joy_t       joy_a_i,
	input  joy_t       joy_b_i,
	input  logic       swap_i,
	output key_event_t key_o,
	output joy_pair_t  joy_o,
	output logic       joy_reset_o
);

	logic    toggle_q;
	numpad_t numpad_q;
	numpad_t numpad;
	logic    ps2_changed;
	logic    joy_changed;
	byte_t   ps2_ascii;
	byte_t   joy_ascii;
	joy_t    joya;
	joy_t    joyb;

	assign numpad      = joy_a_i.numpad | joy_b_i.numpad;
	assign ps2_changed = ps2_key_i.toggle != toggle_q;
	assign joy_changed = numpad != numpad_q;

	////////////////////////////////////////
	// Scancode table
	////////////////////////////////////////

	// Extended flag ignored, set 2 codes only
	always_comb begin
		case (ps2_key_i.code)
			8'h45: ps2_ascii = "0";
			8'h16: ps2_ascii = "1";
			8'h1E: ps2_ascii = "2";
			8'h26: ps2_ascii = "3";
			8'h25: ps2_ascii = "4";
			8'h2E: ps2_ascii = "5";
			8'h36: ps2_ascii = "6";
			8'h3D: ps2_ascii = "7";
			8'h3E: ps2_ascii = "8";
			8'h46: ps2_ascii = "9";
			8'h1C: ps2_ascii = "a";
			8'h32: ps2_ascii = "b";
			8'h21: ps2_ascii = "c";
			8'h23: ps2_ascii = "d";
			8'h24: ps2_ascii = "e";
			8'h2B: ps2_ascii = "f";
			8'h34: ps2_ascii = "g";
			8'h33: ps2_ascii = "h";
			8'h43: ps2_ascii = "i";
			8'h3B: ps2_ascii = "j";
			8'h42: ps2_ascii = "k";
			8'h4B: ps2_ascii = "l";
			8'h3A: ps2_ascii = "m";
			8'h31: ps2_ascii = "n";
			8'h44: ps2_ascii = "o";
			8'h4D: ps2_ascii = "p";
			8'h15: ps2_ascii = "q";
			8'h2D: ps2_ascii = "r";
			8'h1B: ps2_ascii = "s";
			8'h2C: ps2_ascii = "t";
			8'h3C: ps2_ascii = "u";
			8'h2A: ps2_ascii = "v";
			8'h1D: ps2_ascii = "w";
			8'h22: ps2_ascii = "x";
			8'h35: ps2_ascii = "y";
			8'h1A: ps2_ascii = "z";
			8'h29: ps2_ascii = " ";
			// Keypad operators and equals
			8'h79: ps2_ascii = "+";
			8'h7B: ps2_ascii = "-";
			8'h7C: ps2_ascii = "*";
			8'h4A: ps2_ascii = "/";
			8'h55: ps2_ascii = "=";
			// GUI keys act as yes / no
			8'h1F: ps2_ascii = 8'h11;
			8'h27: ps2_ascii = 8'h12;
			8'h5A: ps2_ascii = 8'd10;
			8'h66: ps2_ascii = 8'd8;
			default: ps2_ascii = 8'h00;
		endcase
	end

	// Lowest held button wins, scan from the top down
	always_comb begin
		joy_ascii = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (numpad[i])
				joy_ascii = (i == 9) ? byte_t'("0") : byte_t'(8'h31 + i);
		end
	end

	////////////////////////////////////////
	// Event register
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			numpad_q <= '0;
			key_o    <= '0;
		end else begin
			toggle_q    <= ps2_key_i.toggle;
			numpad_q    <= numpad;
			key_o.ready <= ps2_changed | joy_changed;
			// PS/2 takes priority over the pads
			if (ps2_changed) begin
				key_o.ascii    <= ps2_ascii;
				key_o.released <= ~ps2_key_i.pressed;
			end else begin
				key_o.ascii    <= joy_ascii;
				key_o.released <= numpad == '0;
			end
		end
	end

	////////////////////////////////////////
	// Joystick routing
	////////////////////////////////////////

	assign joya = swap_i ? joy_b_i : joy_a_i;
	assign joyb = swap_i ? joy_a_i : joy_b_i;

	// Console lines are low when pressed
	assign joy_o.up     = {~joya.up, ~joyb.up};
	assign joy_o.down   = {~joya.down, ~joyb.down};
	assign joy_o.left   = {~joya.left, ~joyb.left};
	assign joy_o.right  = {~joya.right, ~joyb.right};
	assign joy_o.action = {~joya.action, ~joyb.action};

	// Both pads pressing reset restarts the console
	assign joy_reset_o = joy_a_i.reset & joy_b_i.reset;

endmodule

`default_nettype wire

// ==== testbench/tb_vp_glue.sv ====
/*
 * Videopac board glue testbench
 * Table driven checks of clock enables, cartridge download and banking,
 * key events, joystick routing, palette, overscan trim and sound.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vp_glue
	import vp_glue_pkg::*;
();

	localparam int TIMEOUT = 100;

	////////////////////////////////////////
	// Stimulus and expected value tables
	////////////////////////////////////////

	// Cart address, bs0, bs1
	localparam logic [13:0] BANK_TAB [8] = '{
		{12'h000, 1'b0, 1'b0}, {12'h3FF, 1'b0, 1'b1},
		{12'h400, 1'b0, 1'b0}, {12'h800, 1'b0, 1'b0},
		{12'hC05, 1'b1, 1'b0}, {12'h123, 1'b1, 1'b1},
		{12'hFFF, 1'b1, 1'b1}, {12'h5A5, 1'b0, 1'b1}
	};
	// Scancode, pressed, expected ascii
	localparam logic [16:0] KB_TAB [8] = '{
		{8'h1C, 1'b1, 8'h61}, {8'h45, 1'b0, 8'h30},
		{8'h29, 1'b1, 8'h20}, {8'h5A, 1'b1, 8'h0A},
		{8'h1F, 1'b0, 8'h11}, {8'h79, 1'b1, 8'h2B},
		{8'h55, 1'b1, 8'h3D}, {8'h77, 1'b1, 8'h00}
	};
	// Pad A numpad, pad B numpad, expected ascii, released
	localparam logic [28:0] PAD_TAB [5] = '{
		{10'h004, 10'h000, 8'h33, 1'b0}, {10'h004, 10'h001, 8'h31, 1'b0},
		{10'h000, 10'h200, 8'h30, 1'b0}, {10'h180, 10'h000, 8'h38, 1'b0},
		{10'h000, 10'h000, 8'h00, 1'b1}
	};
	// Pad A and B as up/down/left/right/action, swap, console lines
	localparam logic [20:0] JOY_TAB [5] = '{
		{5'b10000, 5'b00011, 1'b0, 10'h1FA}, {5'b10000, 5'b00011, 1'b1, 10'h2F5},
		{5'b01100, 5'b00000, 1'b0, 10'h35F}, {5'b00000, 5'b11111, 1'b1, 10'h155},
		{5'b00000, 5'b00000, 1'b0, 10'h3FF}
	};
	// PAL palette select, colour index, RGB
	localparam logic [28:0] COLOR_TAB [8] = '{
		{1'b0, 4'h0, 24'h000000}, {1'b0, 4'h3, 24'h5C80F6},
		{1'b0, 4'h9, 24'hC75151}, {1'b0, 4'hF, 24'hFFFFFF},
		{1'b1, 4'h2, 24'h0000B6}, {1'b1, 4'h7, 24'h49FFFF},
		{1'b1, 4'hC, 24'hB6B600}, {1'b1, 4'hE, 24'hB6B6B6}
	};
	// Sound level, audio sample
	localparam logic [19:0] AUDIO_TAB [5] = '{
		{4'h0, 16'h0000}, {4'h5, 16'h5555}, {4'hA, 16'hAAAA},
		{4'hF, 16'hFFFF}, {4'h3, 16'h3333}
	};

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       pal_i;
	logic       pal_palette_i;
	logic       trim_i;
	logic       swap_i;
	logic       cpu_en_o;
	logic       vdc_en_o;
	logic       console_res_n_o;
	wb_req_t    wb_i;
	logic       wb_ack_o;
	cart_addr_t cart_addr_i;
	logic       bs0_i;
	logic       bs1_i;
	logic       psen_n_i;
	byte_t      cart_data_o;
	ps2_key_t   ps2_key_i;
	joy_t       joy_a_i;
	joy_t       joy_b_i;
	key_event_t key_o;
	joy_pair_t  joy_o;
	color_idx_t color_i;
	logic       hsync_n_i;
	logic       hblank_i;
	rgb_t       rgb_o;
	logic       hblank_o;
	logic       ce_pix_o;
	snd_t       snd_i;
	audio_t     audio_o;
	// Reference copy of the downloaded image
	byte_t      image [4096];

	vp_glue_top #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL),
		.ROM_AW       (13)
	) UUT (.*);

	always #2 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// 4K image, so bs1 never reaches the ROM and address bit 10 is dropped
	function automatic logic [11:0] rom_index(input cart_addr_t a, input logic bs0);
		return {bs0, a[11], a[9:0]};
	endfunction

	function automatic joy_t pad_from_dirs(input logic [4:0] d);
		joy_t p;
		p = '0;
		p.up     = d[4];
		p.down   = d[3];
		p.left   = d[2];
		p.right  = d[1];
		p.action = d[0];
		return p;
	endfunction

	task automatic report_mismatch(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout at %0t ns while waiting for %s", $time, what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic byte_equal(input byte_t got, input byte_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %02h expected %02h", what, got, exp));
	endtask

	task automatic rgb_equal(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %06h expected %06h", what, got, exp));
	endtask

	task automatic key_equal(input key_event_t got, input key_event_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %03h expected %03h", what, got, exp));
	endtask

	task automatic joy_equal(input joy_pair_t got, input joy_pair_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %03h expected %03h", what, got, exp));
	endtask

	task automatic audio_equal(input audio_t got, input audio_t exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %04h expected %04h", what, got, exp));
	endtask

	task automatic bit_equal(input logic got, input logic exp, input string what);
		if (got !== exp)
			report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
	endtask

	task automatic count_equal(input int got, input int exp, input string what);
		if (got != exp)
			report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic step();
		@(posedge clk_sys);
		#1;
	endtask

	// Cycles until the next enable pulse
	task automatic wait_enable(input logic use_vdc, output int cycles);
		int n;
		n = 0;
		do begin
			step();
			n++;
			if (n > TIMEOUT)
				report_timeout(use_vdc ? "VDC enable" : "CPU enable");
		end while (!(use_vdc ? vdc_en_o : cpu_en_o));
		cycles = n;
	endtask

	task automatic wb_write(input rom_addr_t adr, input byte_t dat);
		int n;
		wb_i = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		n = 0;
		do begin
			step();
			n++;
			if (n > TIMEOUT)
				report_timeout("Wishbone ack");
		end while (!wb_ack_o);
		// Transfer completes on the edge where ack is high
		step();
		bit_equal(wb_ack_o, 1'b0, "Wishbone ack pulse width");
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int          gap;
		int          guard;
		int          h_model;
		logic        en_seen;
		logic        tog;
		logic [31:0] seed;
		key_event_t  exp_key;

		reset         = 1'b1;
		pal_i         = 1'b0;
		pal_palette_i = 1'b0;
		trim_i        = 1'b0;
		swap_i        = 1'b0;
		wb_i          = '0;
		cart_addr_i   = '0;
		bs0_i         = 1'b0;
		bs1_i         = 1'b0;
		psen_n_i      = 1'b1;
		ps2_key_i     = '0;
		joy_a_i       = '0;
		joy_b_i       = '0;
		color_i       = '0;
		hsync_n_i     = 1'b1;
		hblank_i      = 1'b0;
		snd_i         = '0;
		repeat (4) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		#1;

		// NTSC enable spacing
		bit_equal(console_res_n_o, 1'b1, "console reset after reset");
		wait_enable(1'b0, gap);
		wait_enable(1'b0, gap);
		count_equal(gap, CPU_DIV_NTSC, "NTSC CPU enable spacing");
		wait_enable(1'b1, gap);
		wait_enable(1'b1, gap);
		count_equal(gap, VDC_DIV_NTSC, "NTSC VDC enable spacing");

		// Standard change pulses the console reset for one cycle
		pal_i = 1'b1;
		#1;
		bit_equal(console_res_n_o, 1'b0, "console reset on standard change");
		step();
		bit_equal(console_res_n_o, 1'b1, "console reset after standard change");
		wait_enable(1'b0, gap);
		wait_enable(1'b0, gap);
		count_equal(gap, CPU_DIV_PAL, "PAL CPU enable spacing");
		wait_enable(1'b1, gap);
		wait_enable(1'b1, gap);
		count_equal(gap, VDC_DIV_PAL, "PAL VDC enable spacing");

		// Download a 4K image
		seed = 32'd68;
		for (int i = 0; i < BANK0_SIZE; i++) begin
			seed     = lcg_next(seed);
			image[i] = seed[23:16];
			wb_write(rom_addr_t'(i), image[i]);
			if (i == 0 || i == BANK0_SIZE / 2)
				bit_equal(console_res_n_o, 1'b0, "console reset during download");
		end
		wb_i = '0;
		#1;
		bit_equal(console_res_n_o, 1'b1, "console reset after download");
		step();

		// Banked reads, one cycle latency
		for (int i = 0; i < 8; i++) begin
			cart_addr_i = BANK_TAB[i][13:2];
			bs0_i       = BANK_TAB[i][1];
			bs1_i       = BANK_TAB[i][0];
			psen_n_i    = 1'b0;
			step();
			byte_equal(cart_data_o, image[rom_index(cart_addr_i, bs0_i)],
				$sformatf("cart read at %03h", cart_addr_i));
		end
		psen_n_i = 1'b1;
		step();
		byte_equal(cart_data_o, 8'hFF, "cart data with psen_n high");

		// PS/2 keys, new key on each toggle flip
		tog = 1'b0;
		for (int i = 0; i < 8; i++) begin
			tog       = ~tog;
			ps2_key_i = '{toggle: tog, pressed: KB_TAB[i][8], extended: 1'b0,
				code: KB_TAB[i][16:9]};
			step();
			exp_key = '{ready: 1'b1, released: ~KB_TAB[i][8], ascii: KB_TAB[i][7:0]};
			key_equal(key_o, exp_key, "PS/2 key event");
			step();
			bit_equal(key_o.ready, 1'b0, "PS/2 ready pulse width");
		end

		// Number buttons of both pads
		for (int i = 0; i < 5; i++) begin
			joy_a_i.numpad = PAD_TAB[i][28:19];
			joy_b_i.numpad = PAD_TAB[i][18:9];
			step();
			exp_key = '{ready: 1'b1, released: PAD_TAB[i][0], ascii: PAD_TAB[i][8:1]};
			key_equal(key_o, exp_key, "numpad key event");
			step();
			bit_equal(key_o.ready, 1'b0, "numpad ready pulse width");
		end

		// Directions, active low with optional swap
		for (int i = 0; i < 5; i++) begin
			step();
			joy_a_i = pad_from_dirs(JOY_TAB[i][20:16]);
			joy_b_i = pad_from_dirs(JOY_TAB[i][15:11]);
			swap_i  = JOY_TAB[i][10];
			#1;
			joy_equal(joy_o, joy_pair_t'(JOY_TAB[i][9:0]), "joystick routing");
		end
		step();

		// Console reset needs both pad reset buttons
		joy_a_i.reset = 1'b1;
		#1;
		bit_equal(console_res_n_o, 1'b1, "console reset with one pad reset");
		step();
		joy_b_i.reset = 1'b1;
		#1;
		bit_equal(console_res_n_o, 1'b0, "console reset with both pad resets");
		step();
		joy_a_i = '0;
		joy_b_i = '0;
		#1;
		bit_equal(console_res_n_o, 1'b1, "console reset after pad resets");
		step();

		// Both palettes
		for (int i = 0; i < 8; i++) begin
			pal_palette_i = COLOR_TAB[i][28];
			color_i       = COLOR_TAB[i][27:24];
			step();
			rgb_equal(rgb_o, COLOR_TAB[i][23:0], "palette colour");
		end

		// Trim window, hsync falls on the next VDC enable
		trim_i = 1'b1;
		wait_enable(1'b1, gap);
		hsync_n_i = 1'b0;
		step();
		h_model = 0;
		bit_equal(hblank_o, 1'b1, "trimmed hblank at line start");
		guard = 0;
		while (h_model < TRIM_RIGHT + 8) begin
			en_seen = vdc_en_o;
			step();
			guard++;
			if (guard > 5000)
				report_timeout("trim counter sweep");
			if (en_seen)
				h_model++;
			bit_equal(hblank_o, (h_model <= TRIM_LEFT) || (h_model >= TRIM_RIGHT),
				$sformatf("trimmed hblank at count %0d", h_model));
			// PAL VDC cadence, counted from the enable that started the line
			bit_equal(ce_pix_o, ((guard + 1) % VDC_DIV_PAL) == 0, "pixel enable");
		end

		// Untrimmed blank follows the console
		trim_i   = 1'b0;
		hblank_i = 1'b1;
		#1;
		bit_equal(hblank_o, 1'b1, "untrimmed hblank high");
		step();
		hblank_i = 1'b0;
		#1;
		bit_equal(hblank_o, 1'b0, "untrimmed hblank low");

		// Sound widening
		for (int i = 0; i < 5; i++) begin
			step();
			snd_i = AUDIO_TAB[i][19:16];
			#1;
			audio_equal(audio_o, AUDIO_TAB[i][15:0], "audio sample");
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/vp_clock_reset.sv ====
/*
 * Videopac clock enables and console reset
 * Divides clk_sys into CPU and VDC enables per NTSC/PAL standard
 * and holds the console in reset on download or standard change.
 */
`timescale 1ns/1ps
`default_nettype none

module vp_clock_reset #(
	parameter int CPU_DIV_NTSC = vp_glue_pkg::CPU_DIV_NTSC,
	parameter int CPU_DIV_PAL  = vp_glue_pkg::CPU_DIV_PAL,
	parameter int VDC_DIV_NTSC = vp_glue_pkg::VDC_DIV_NTSC,
	parameter int VDC_DIV_PAL  = vp_glue_pkg::VDC_DIV_PAL
) (
	input  wire  clk_sys,
	input  wire  reset,
	input  logic pal_i,
	input  logic dl_active_i,
	input  logic joy_reset_i,
	output logic cpu_en_o,
	output logic vdc_en_o,
	output logic console_res_n_o
);

	// Wide enough for the largest divisor
	localparam int CW = 8;

	logic          pal_q;
	logic          pal_change;
	logic [CW-1:0] cpu_cnt;
	logic [CW-1:0] vdc_cnt;
	logic [CW-1:0] cpu_last;
	logic [CW-1:0] vdc_last;

	// Terminal counts for the selected standard
	assign cpu_last   = pal_i ? CW'(CPU_DIV_PAL - 1) : CW'(CPU_DIV_NTSC - 1);
	assign vdc_last   = pal_i ? CW'(VDC_DIV_PAL - 1) : CW'(VDC_DIV_NTSC - 1);
	assign pal_change = pal_q != pal_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q    <= 1'b0;
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			pal_q <= pal_i;
			// Standard change restarts both dividers
			if (pal_change) begin
				cpu_cnt  <= '0;
				vdc_cnt  <= '0;
				cpu_en_o <= 1'b0;
				vdc_en_o <= 1'b0;
			end else begin
				cpu_en_o <= cpu_cnt == cpu_last;
				cpu_cnt  <= (cpu_cnt == cpu_last) ? '0 : cpu_cnt + 1'b1;
				vdc_en_o <= vdc_cnt == vdc_last;
				vdc_cnt  <= (vdc_cnt == vdc_last) ? '0 : vdc_cnt + 1'b1;
			end
		end
	end

	// Low active console reset
	assign console_res_n_o = ~(reset | dl_active_i | joy_reset_i | pal_change);

endmodule

`default_nettype wire

// ==== verilog/vp_glue_top.sv ====
/*
 * Videopac board glue top level
 * Joins clock/reset, cartridge ROM, input front end and video
 * encoder around the console core, and widens the console sound.
 */
`timescale 1ns/1ps
`default_nettype none

module vp_glue_top
	import vp_glue_pkg::*;
#(
	parameter int CPU_DIV_NTSC = vp_glue_pkg::CPU_DIV_NTSC,
	parameter int CPU_DIV_PAL  = vp_glue_pkg::CPU_DIV_PAL,
	parameter int VDC_DIV_NTSC = vp_glue_pkg::VDC_DIV_NTSC,
	parameter int VDC_DIV_PAL  = vp_glue_pkg::VDC_DIV_PAL,
	parameter int ROM_AW       = 13
) (
	input  wire        clk_sys,
	input  wire        reset,
	// Standard and options
	input  logic       pal_i,
	input  logic       pal_palette_i,
	input  logic       trim_i,
	input  logic       swap_i,
	output logic       cpu_en_o,
	output logic       vdc_en_o,
	output logic       console_res_n_o,
	// Cartridge download
	input  wb_req_t    wb_i,
	output logic       wb_ack_o,
	// Console cartridge bus
	input  cart_addr_t cart_addr_i,
	input  logic       bs0_i,
	input  logic       bs1_i,
	input  logic       psen_n_i,
	output byte_t      cart_data_o,
	// Keyboard and joysticks
	input  ps2_key_t   ps2_key_i,
	input  joy_t       joy_a_i,
	input  joy_t       joy_b_i,
	output key_event_t key_o,
	output joy_pair_t  joy_o,
	// Video
	input  color_idx_t color_i,
	input  logic       hsync_n_i,
	input  logic       hblank_i,
	output rgb_t       rgb_o,
	output logic       hblank_o,
	output logic       ce_pix_o,
	// Sound
	input  snd_t       snd_i,
	output audio_t     audio_o
);

	logic dl_active;
	logic joy_reset;

	////////////////////////////////////////
	// Block instances
	////////////////////////////////////////

	vp_clock_reset #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL)
	) u_clock_reset (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.pal_i           (pal_i),
		.dl_active_i     (dl_active),
		.joy_reset_i     (joy_reset),
		.cpu_en_o        (cpu_en_o),
		.vdc_en_o        (vdc_en_o),
		.console_res_n_o (console_res_n_o)
	);

	vp_cart_rom #(
		.ROM_AW (ROM_AW)
	) u_cart_rom (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.wb_i        (wb_i),
		.wb_ack_o    (wb_ack_o),
		.dl_active_o (dl_active),
		.cart_addr_i (cart_addr_i),
		.bs0_i       (bs0_i),
		.bs1_i       (bs1_i),
		.psen_n_i    (psen_n_i),
		.cart_data_o (cart_data_o)
	);

	vp_input_front u_input_front (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key_i   (ps2_key_i),
		.joy_a_i     (joy_a_i),
		.joy_b_i     (joy_b_i),
		.swap_i      (swap_i),
		.key_o       (key_o),
		.joy_o       (joy_o),
		.joy_reset_o (joy_reset)
	);

	// Pixel clock follows the VDC enable
	vp_video_encoder u_video_encoder (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.vdc_en_i      (vdc_en_o),
		.pal_palette_i (pal_palette_i),
		.trim_i        (trim_i),
		.color_i       (color_i),
		.hsync_n_i     (hsync_n_i),
		.hblank_i      (hblank_i),
		.rgb_o         (rgb_o),
		.hblank_o      (hblank_o),
		.ce_pix_o      (ce_pix_o)
	);

	// 4-bit level repeated to fill the sample
	assign audio_o = {4{snd_i}};

endmodule

`default_nettype wire

// ==== verilog/vp_video_encoder.sv ====
/*
 * Videopac video encoder
 * Maps the 4-bit colour index onto calibrated NTSC or PAL RGB and
 * narrows the horizontal blank for overscan trimming.
 */
`timescale 1ns/1ps
`default_nettype none

module vp_video_encoder
	import vp_glue_pkg::*;
(
	input  wire        clk_sys,
	input  wire        reset,
	input  logic       vdc_en_i,
	input  logic       pal_palette_i,
	input  logic       trim_i,
	input  color_idx_t color_i,
	input  logic       hsync_n_i,
	input  logic       hblank_i,
	output rgb_t       rgb_o,
	output logic       hblank_o,
	output logic       ce_pix_o
);

	// Even entries plain, odd entries with luma
	localparam rgb_t LUT_NTSC [16] = '{
		24'h000000, 24'h676767,
		24'h1A37BE, 24'h5C80F6,
		24'h006D07, 24'h56C469,
		24'h2AAABE, 24'h77E6EB,
		24'h790000, 24'hC75151,
		24'h94309F, 24'hDC84E8,
		24'h77670B, 24'hC6B86A,
		24'hCECECE, 24'hFFFFFF
	};

	// Flatter saturated set for PAL sets
	localparam rgb_t LUT_PAL [16] = '{
		24'h000000, 24'h494949,
		24'h0000B6, 24'h4949FF,
		24'h00B601, 24'h49FF49,
		24'h00B6C9, 24'h49FFFF,
		24'hB60000, 24'hFF4949,
		24'hB600B6, 24'hFF49FF,
		24'hB6B600, 24'hFFFF49,
		24'hB6B6B6, 24'hFFFFFF
	};

	logic        hsync_n_q;
	logic [15:0] h_cnt;

	// Palette output register, no reset on pixel data
	always_ff @(posedge clk_sys) begin
		rgb_o <= pal_palette_i ? LUT_PAL[color_i] : LUT_NTSC[color_i];
	end

	////////////////////////////////////////
	// Horizontal position counter
	////////////////////////////////////////

	// Counts VDC clocks, zeroed where hsync goes active
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hsync_n_q <= 1'b1;
			h_cnt     <= '0;
		end else if (vdc_en_i) begin
			hsync_n_q <= hsync_n_i;
			if (hsync_n_q && !hsync_n_i)
				h_cnt <= '0;
			else
				h_cnt <= h_cnt + 1'b1;
		end
	end

	// Trimmed blank hides the ragged borders
	assign hblank_o = trim_i ?
		((h_cnt <= 16'(TRIM_LEFT)) || (h_cnt >= 16'(TRIM_RIGHT))) : hblank_i;

	assign ce_pix_o = vdc_en_i;

endmodule

`default_nettype wire
